/* tb.f */
+incdir+logic
logic/vout_pkg.sv
logic/vid_stream_if.sv
logic/osd_mixer.sv
logic/analog_sync_encoder.sv
logic/video_out_top.sv
verif/tb_clk_gen.sv
verif/video_out_props.sv
verif/tb_top.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert --timescale 1ns/1ps
TOP       := tb_top
FILELIST  := tb.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
FAIL_MSG  := STATUS: FAIL
PASS_MSG  := STATUS: PASS

SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard logic/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	-$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation failed"; \
		exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a pass status"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/tb_top.sv */
`timescale 1ns/1ps

`include "vout_cfg.svh"

module tb_top
    import vout_pkg::*;
();

    // Mixed sample, also the HDMI expectation
    typedef struct packed {
        rgb_t pix;
        logic hs;
        logic vs;
        logic de;
    } mix_t;

    typedef struct packed {
        rgb_t pix;
        logic hs;
        logic vs;
        logic blank_n;
        logic sync_n;
    } dac_t;

    typedef struct packed {
        logic [23:0]   pix;
        logic [2:0]    sync;
        logic          osd_en;
        osd_color_e    col;
        ext_out_mode_e mode;
        logic          pwr;
        logic          rnd;
        logic [2:0]    rep;
    } row_t;

    localparam int NUM_ROWS = 28;

    logic pclk_out, po_reset_n, sys_poweron_i;
    logic [`VOUT_COLOR_W-1:0] pix_r_i, pix_g_i, pix_b_i;
    logic hsync_i, vsync_i, de_i, osd_enable_i;
    logic [1:0] osd_color_i, ext_out_mode_i;
    logic [`VOUT_COLOR_W-1:0] hdmitx_r_o, hdmitx_g_o, hdmitx_b_o;
    logic hdmitx_hsync_o, hdmitx_vsync_o, hdmitx_de_o;
    logic [`VOUT_COLOR_W-1:0] vga_r_o, vga_g_o, vga_b_o;
    logic vga_hs_o, vga_vs_o, vga_blank_n_o, vga_sync_n_o, vga_psave_n_o;

    rgb_t osd_lut [4] = '{`VOUT_OSD_BLACK, `VOUT_OSD_BLUE, `VOUT_OSD_YELLOW, `VOUT_OSD_WHITE};

    // pix, {hsync,vsync,de}, osd_en, osd color, mode, poweron, random pix, cycles
    row_t rows [NUM_ROWS] = '{
        '{24'h102030, 3'b111, 1'b0, OSD_BLACK,  EXT_RGBHV, 1'b1, 1'b0, 3'd2},
        '{24'h000000, 3'b101, 1'b0, OSD_BLACK,  EXT_RGBHV, 1'b1, 1'b1, 3'd3},
        '{24'h000000, 3'b011, 1'b0, OSD_WHITE,  EXT_RGBHV, 1'b1, 1'b1, 3'd2},
        '{24'h123456, 3'b111, 1'b1, OSD_BLACK,  EXT_RGBHV, 1'b1, 1'b0, 3'd2},
        '{24'h654321, 3'b101, 1'b1, OSD_BLUE,   EXT_RGBHV, 1'b1, 1'b0, 3'd1},
        '{24'h000000, 3'b011, 1'b1, OSD_YELLOW, EXT_RGBHV, 1'b1, 1'b1, 3'd2},
        '{24'h000000, 3'b110, 1'b1, OSD_WHITE,  EXT_RGBHV, 1'b1, 1'b1, 3'd1},
        '{24'h000000, 3'b111, 1'b0, OSD_BLACK,  EXT_RGBCS, 1'b1, 1'b1, 3'd2},
        '{24'h000000, 3'b011, 1'b0, OSD_BLACK,  EXT_RGBCS, 1'b1, 1'b1, 3'd1},
        '{24'h000000, 3'b101, 1'b0, OSD_BLACK,  EXT_RGBCS, 1'b1, 1'b1, 3'd2},
        '{24'h808080, 3'b110, 1'b1, OSD_YELLOW, EXT_RGBCS, 1'b1, 1'b0, 3'd1},
        '{24'h000000, 3'b111, 1'b0, OSD_BLACK,  EXT_RGSB,  1'b1, 1'b1, 3'd1},
        '{24'h000000, 3'b101, 1'b0, OSD_BLACK,  EXT_RGSB,  1'b1, 1'b1, 3'd2},
        '{24'h00ff00, 3'b000, 1'b1, OSD_BLUE,   EXT_RGSB,  1'b1, 1'b0, 3'd2},
        '{24'h000000, 3'b111, 1'b0, OSD_BLACK,  EXT_RGSB,  1'b1, 1'b1, 3'd3},
        '{24'h000000, 3'b101, 1'b0, OSD_BLACK,  EXT_OFF,   1'b1, 1'b1, 3'd3},
        '{24'h000000, 3'b010, 1'b0, OSD_BLACK,  EXT_OFF,   1'b1, 1'b1, 3'd2},
        '{24'hffffff, 3'b111, 1'b1, OSD_WHITE,  EXT_OFF,   1'b1, 1'b0, 3'd1},
        '{24'h112233, 3'b111, 1'b0, OSD_BLACK,  EXT_RGBHV, 1'b1, 1'b0, 3'd1},
        '{24'h000000, 3'b110, 1'b0, OSD_BLACK,  EXT_RGBHV, 1'b1, 1'b1, 3'd2},
        '{24'h000000, 3'b111, 1'b0, OSD_BLACK,  EXT_RGBCS, 1'b0, 1'b1, 3'd2},
        '{24'h000000, 3'b101, 1'b0, OSD_BLACK,  EXT_OFF,   1'b0, 1'b1, 3'd2},
        '{24'h000000, 3'b011, 1'b0, OSD_BLACK,  EXT_RGSB,  1'b0, 1'b1, 3'd1},
        '{24'h000000, 3'b110, 1'b1, OSD_BLUE,   EXT_RGSB,  1'b1, 1'b1, 3'd2},
        '{24'h000000, 3'b111, 1'b0, OSD_BLACK,  EXT_RGBHV, 1'b1, 1'b1, 3'd1},
        '{24'h000000, 3'b100, 1'b0, OSD_BLACK,  EXT_OFF,   1'b1, 1'b1, 3'd1},
        '{24'h000000, 3'b011, 1'b1, OSD_BLACK,  EXT_RGBCS, 1'b1, 1'b1, 3'd1},
        '{24'h000000, 3'b110, 1'b0, OSD_BLACK,  EXT_RGBHV, 1'b1, 1'b1, 3'd4}
    };

    mix_t          hdmi_q[$];
    mix_t          vga_q[$];
    dac_t          s1_m;
    dac_t          s2_m;
    ext_out_mode_e last_mode;
    logic          last_pwr;
    int            err_count;
    int            cycle_cnt = 0;
    int            cycle_limit;

    tb_clk_gen clk_gen_i (.clk_o(pclk_out), .rst_n_o(po_reset_n));

    video_out_top dut_i (.*);

    function automatic dac_t dac_encode(input mix_t m, input ext_out_mode_e mode);
        dac_t d;
        logic cs;
        // Composite sync is high when both syncs agree
        cs = (m.hs == m.vs);
        d.pix = m.pix;
        d.blank_n = m.de;
        d.hs = (mode == EXT_RGBHV) ? m.hs : cs;
        d.vs = (mode == EXT_RGBHV) ? m.vs : 1'b1;
        d.sync_n = (mode == EXT_RGSB) && cs;
        return d;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            err_count++;
            $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, want);
            $display("STATUS: FAIL");
            $fatal(1, "Value mismatch on %s", name);
        end
    endtask

    task automatic check_outputs_zero();
        check_val("hdmitx outputs", 32'({hdmitx_r_o, hdmitx_g_o, hdmitx_b_o,
                  hdmitx_hsync_o, hdmitx_vsync_o, hdmitx_de_o}), 32'd0);
        check_val("vga outputs", 32'({vga_r_o, vga_g_o, vga_b_o, vga_hs_o, vga_vs_o,
                  vga_blank_n_o, vga_sync_n_o, vga_psave_n_o}), 32'd0);
    endtask

    task automatic run_cycle(input row_t row);
        mix_t        hexp;
        mix_t        ventry;
        mix_t        mixed;
        rgb_t        pix;
        logic [31:0] rnd_word;
        @(posedge pclk_out);
        #1;
        hexp = hdmi_q.pop_front();
        check_val("hdmitx_rgb", 32'({hdmitx_r_o, hdmitx_g_o, hdmitx_b_o}), 32'(hexp.pix));
        check_val("hdmitx_hsync_o", 32'(hdmitx_hsync_o), 32'(hexp.hs));
        check_val("hdmitx_vsync_o", 32'(hdmitx_vsync_o), 32'(hexp.vs));
        check_val("hdmitx_de_o", 32'(hdmitx_de_o), 32'(hexp.de));
        // Both DAC stages move only on an edge that saw a mode other than off
        ventry = vga_q.pop_front();
        if (last_mode != EXT_OFF) begin
            s2_m = s1_m;
            s1_m = dac_encode(ventry, last_mode);
        end
        check_val("vga_rgb", 32'({vga_r_o, vga_g_o, vga_b_o}), 32'(s2_m.pix));
        check_val("vga_hs_o", 32'(vga_hs_o), 32'(s2_m.hs));
        check_val("vga_vs_o", 32'(vga_vs_o), 32'(s2_m.vs));
        check_val("vga_blank_n_o", 32'(vga_blank_n_o), 32'(s2_m.blank_n));
        check_val("vga_sync_n_o", 32'(vga_sync_n_o), 32'(s2_m.sync_n));
        check_val("vga_psave_n_o", 32'(vga_psave_n_o), 32'(last_pwr && last_mode != EXT_OFF));
        #1;
        rnd_word = $urandom();
        pix = row.rnd ? rnd_word[23:0] : row.pix;
        pix_r_i = pix.r;
        pix_g_i = pix.g;
        pix_b_i = pix.b;
        {hsync_i, vsync_i, de_i} = row.sync;
        osd_enable_i = row.osd_en;
        osd_color_i = row.col;
        ext_out_mode_i = row.mode;
        sys_poweron_i = row.pwr;
        mixed.pix = row.osd_en ? osd_lut[row.col] : pix;
        {mixed.hs, mixed.vs, mixed.de} = row.sync;
        hdmi_q.push_back(mixed);
        vga_q.push_back(mixed);
        last_mode = row.mode;
        last_pwr = row.pwr;
    endtask

    initial begin
        void'($urandom(32'hf07e8516));
        {sys_poweron_i, pix_r_i, pix_g_i, pix_b_i} = '0;
        {hsync_i, vsync_i, de_i, osd_enable_i, osd_color_i, ext_out_mode_i} = '0;
        err_count = 0;
        s1_m = '0;
        s2_m = '0;
        last_mode = EXT_OFF;
        last_pwr = 1'b0;
        cycle_limit = 20 + 2 + `VOUT_VGA_LAT;
        foreach (rows[i]) cycle_limit += int'(rows[i].rep);
        // Idle samples already in flight when reset releases
        repeat (`VOUT_HDMI_LAT) hdmi_q.push_back('0);
        repeat (`VOUT_VGA_LAT - 1) vga_q.push_back('0);
        repeat (2) begin
            @(posedge pclk_out);
            #1;
            check_outputs_zero();
        end
        @(posedge po_reset_n);
        foreach (rows[i]) begin
            repeat (rows[i].rep) run_cycle(rows[i]);
        end
        // Drain the last row through both paths
        repeat (`VOUT_VGA_LAT) run_cycle(rows[NUM_ROWS-1]);
        if (err_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    always @(posedge pclk_out) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("Timeout: the test did not finish within %0d clock cycles", cycle_limit);
            $display("STATUS: FAIL");
            $fatal(1, "Simulation timeout");
        end
    end

endmodule

/* verif/video_out_props.sv */
`timescale 1ns/1ps

`include "vout_cfg.svh"

module video_out_props
    import vout_pkg::*;
(
    input logic                     pclk_out,
    input logic                     po_reset_n,
    input logic                     sys_poweron_i,
    input logic [1:0]               ext_out_mode_i,
    input logic                     hdmitx_hsync_o,
    input logic                     hdmitx_vsync_o,
    input logic                     hdmitx_de_o,
    input logic [`VOUT_COLOR_W-1:0] vga_r_o,
    input logic [`VOUT_COLOR_W-1:0] vga_g_o,
    input logic [`VOUT_COLOR_W-1:0] vga_b_o,
    input logic                     vga_hs_o,
    input logic                     vga_vs_o,
    input logic                     vga_blank_n_o,
    input logic                     vga_sync_n_o,
    input logic                     vga_psave_n_o
);

    logic ctrl_idle;

    assign ctrl_idle = !hdmitx_de_o && !hdmitx_hsync_o && !hdmitx_vsync_o &&
                       !vga_blank_n_o && !vga_sync_n_o;

    a_reset_idle: assert property (@(posedge pclk_out) !po_reset_n |-> ctrl_idle)
        else $error("control outputs not cleared during reset");

    a_first_cycle_idle: assert property (@(posedge pclk_out) $rose(po_reset_n) |=> ctrl_idle)
        else $error("control outputs not cleared in the first cycle after reset");

    a_psave: assert property (@(posedge pclk_out)
        vga_psave_n_o == (sys_poweron_i && ext_out_mode_i != EXT_OFF))
        else $error("vga_psave_n_o does not follow poweron and mode");

    // DAC pins frozen for an edge that sees the off mode
    a_off_hold: assert property (@(posedge pclk_out) disable iff (!po_reset_n)
        ext_out_mode_i == EXT_OFF |=> $stable({vga_r_o, vga_g_o, vga_b_o, vga_hs_o,
                                               vga_vs_o, vga_blank_n_o, vga_sync_n_o}))
        else $error("analog outputs changed in off mode");

endmodule

bind video_out_top video_out_props props_i (.*);

/* verif/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 2;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    // Reset released on a falling edge, away from the capture edge
    initial begin
        rst_n_o = 1'b1;
        #1;
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule

/* logic/video_out_top.sv */
`timescale 1ns/1ps

`include "vout_cfg.svh"

module video_out_top
    import vout_pkg::*;
(
    input  logic                     pclk_out,
    input  logic                     po_reset_n,
    input  logic                     sys_poweron_i,
    input  logic [`VOUT_COLOR_W-1:0] pix_r_i,
    input  logic [`VOUT_COLOR_W-1:0] pix_g_i,
    input  logic [`VOUT_COLOR_W-1:0] pix_b_i,
    input  logic                     hsync_i,
    input  logic                     vsync_i,
    input  logic                     de_i,
    input  logic                     osd_enable_i,
    input  logic [1:0]               osd_color_i,
    input  logic [1:0]               ext_out_mode_i,
    output logic [`VOUT_COLOR_W-1:0] hdmitx_r_o,
    output logic [`VOUT_COLOR_W-1:0] hdmitx_g_o,
    output logic [`VOUT_COLOR_W-1:0] hdmitx_b_o,
    output logic                     hdmitx_hsync_o,
    output logic                     hdmitx_vsync_o,
    output logic                     hdmitx_de_o,
    output logic [`VOUT_COLOR_W-1:0] vga_r_o,
    output logic [`VOUT_COLOR_W-1:0] vga_g_o,
    output logic [`VOUT_COLOR_W-1:0] vga_b_o,
    output logic                     vga_hs_o,
    output logic                     vga_vs_o,
    output logic                     vga_blank_n_o,
    output logic                     vga_sync_n_o,
    output logic                     vga_psave_n_o
);

    rgb_t pix_in;
    rgb_t hdmitx_pix;
    rgb_t vga_pix;

    vid_stream_if mix_bus ();

    assign pix_in = '{r: pix_r_i, g: pix_g_i, b: pix_b_i};

    osd_mixer u_osd_mixer (
        .pclk_out       (pclk_out),
        .po_reset_n     (po_reset_n),
        .pix_i          (pix_in),
        .hsync_i        (hsync_i),
        .vsync_i        (vsync_i),
        .de_i           (de_i),
        .osd_enable_i   (osd_enable_i),
        .osd_color_i    (osd_color_e'(osd_color_i)),
        .out            (mix_bus.src),
        .hdmitx_pix_o   (hdmitx_pix),
        .hdmitx_hsync_o (hdmitx_hsync_o),
        .hdmitx_vsync_o (hdmitx_vsync_o),
        .hdmitx_de_o    (hdmitx_de_o)
    );

    analog_sync_encoder u_analog_sync_encoder (
        .pclk_out       (pclk_out),
        .po_reset_n     (po_reset_n),
        .in             (mix_bus.snk),
        .ext_out_mode_i (ext_out_mode_e'(ext_out_mode_i)),
        .sys_poweron_i  (sys_poweron_i),
        .vga_pix_o      (vga_pix),
        .vga_hs_o       (vga_hs_o),
        .vga_vs_o       (vga_vs_o),
        .vga_blank_n_o  (vga_blank_n_o),
        .vga_sync_n_o   (vga_sync_n_o),
        .vga_psave_n_o  (vga_psave_n_o)
    );

    assign {hdmitx_r_o, hdmitx_g_o, hdmitx_b_o} = hdmitx_pix;
    assign {vga_r_o, vga_g_o, vga_b_o} = vga_pix;

endmodule

/* logic/analog_sync_encoder.sv */
`timescale 1ns/1ps

module analog_sync_encoder
    import vout_pkg::*;
(
    input  logic          pclk_out,
    input  logic          po_reset_n,
    vid_stream_if.snk     in,
    input  ext_out_mode_e ext_out_mode_i,
    input  logic          sys_poweron_i,
    output rgb_t          vga_pix_o,
    output logic          vga_hs_o,
    output logic          vga_vs_o,
    output logic          vga_blank_n_o,
    output logic          vga_sync_n_o,
    output logic          vga_psave_n_o
);

    logic dac_en;
    logic csync;
    logic hs_d;
    logic vs_d;
    logic sync_n_d;

    rgb_t s1_pix;
    logic s1_hs;
    logic s1_vs;
    logic s1_blank_n;
    logic s1_sync_n;

    assign dac_en = (ext_out_mode_i != EXT_OFF);

    // Composite sync, low while exactly one of hsync and vsync is low
    assign csync = ~(in.hsync ^ in.vsync);

    always_comb begin
        hs_d     = (ext_out_mode_i == EXT_RGBHV) ? in.hsync : csync;
        vs_d     = (ext_out_mode_i == EXT_RGBHV) ? in.vsync : 1'b1;
        sync_n_d = (ext_out_mode_i == EXT_RGSB) ? csync : 1'b0;
    end

    // First DAC stage
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            s1_pix     <= '0;
            s1_hs      <= 1'b0;
            s1_vs      <= 1'b0;
            s1_blank_n <= 1'b0;
            s1_sync_n  <= 1'b0;
        end else if (dac_en) begin
            s1_pix     <= in.pix;
            s1_hs      <= hs_d;
            s1_vs      <= vs_d;
            s1_blank_n <= in.de;
            s1_sync_n  <= sync_n_d;
        end
    end

    // Second stage drives the DAC pins
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            vga_pix_o     <= '0;
            vga_hs_o      <= 1'b0;
            vga_vs_o      <= 1'b0;
            vga_blank_n_o <= 1'b0;
            vga_sync_n_o  <= 1'b0;
        end else if (dac_en) begin
            vga_pix_o     <= s1_pix;
            vga_hs_o      <= s1_hs;
            vga_vs_o      <= s1_vs;
            vga_blank_n_o <= s1_blank_n;
            vga_sync_n_o  <= s1_sync_n;
        end
    end

    // DAC powered only while a mode is selected
    assign vga_psave_n_o = sys_poweron_i & dac_en;

endmodule

/* logic/osd_mixer.sv */
`timescale 1ns/1ps

`include "vout_cfg.svh"

module osd_mixer
    import vout_pkg::*;
(
    input  logic          pclk_out,
    input  logic          po_reset_n,
    input  rgb_t          pix_i,
    input  logic          hsync_i,
    input  logic          vsync_i,
    input  logic          de_i,
    input  logic          osd_enable_i,
    input  osd_color_e    osd_color_i,
    vid_stream_if.src     out,
    output rgb_t          hdmitx_pix_o,
    output logic          hdmitx_hsync_o,
    output logic          hdmitx_vsync_o,
    output logic          hdmitx_de_o
);

    rgb_t osd_rgb;
    rgb_t mix_pix_q;
    logic mix_hsync_q;
    logic mix_vsync_q;
    logic mix_de_q;

    always_comb begin
        case (osd_color_i)
            OSD_BLACK:  osd_rgb = `VOUT_OSD_BLACK;
            OSD_BLUE:   osd_rgb = `VOUT_OSD_BLUE;
            OSD_YELLOW: osd_rgb = `VOUT_OSD_YELLOW;
            default:    osd_rgb = `VOUT_OSD_WHITE;
        endcase
    end

    // OSD substitution stage
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            mix_pix_q   <= '0;
            mix_hsync_q <= 1'b0;
            mix_vsync_q <= 1'b0;
            mix_de_q    <= 1'b0;
        end else begin
            mix_pix_q   <= osd_enable_i ? osd_rgb : pix_i;
            mix_hsync_q <= hsync_i;
            mix_vsync_q <= vsync_i;
            mix_de_q    <= de_i;
        end
    end

    assign out.pix   = mix_pix_q;
    assign out.hsync = mix_hsync_q;
    assign out.vsync = mix_vsync_q;
    assign out.de    = mix_de_q;

    // Launch register toward the HDMI transmitter
    always_ff @(posedge pclk_out or negedge po_reset_n) begin
        if (!po_reset_n) begin
            hdmitx_pix_o   <= '0;
            hdmitx_hsync_o <= 1'b0;
            hdmitx_vsync_o <= 1'b0;
            hdmitx_de_o    <= 1'b0;
        end else begin
            hdmitx_pix_o   <= mix_pix_q;
            hdmitx_hsync_o <= mix_hsync_q;
            hdmitx_vsync_o <= mix_vsync_q;
            hdmitx_de_o    <= mix_de_q;
        end
    end

endmodule

/* logic/vid_stream_if.sv */
`timescale 1ns/1ps

// One pixel per pclk_out cycle, no flow control
interface vid_stream_if
    import vout_pkg::*;
();

    rgb_t pix;
    logic hsync;
    logic vsync;
    logic de;

    modport src (
        output pix,
        output hsync,
        output vsync,
        output de
    );

    modport snk (
        input pix,
        input hsync,
        input vsync,
        input de
    );

endinterface

/* logic/vout_pkg.sv */
`include "vout_cfg.svh"

package vout_pkg;

    // One pixel, 24 bits packed
    typedef struct packed {
        logic [`VOUT_COLOR_W-1:0] r;
        logic [`VOUT_COLOR_W-1:0] g;
        logic [`VOUT_COLOR_W-1:0] b;
    } rgb_t;

    typedef enum logic [1:0] {
        OSD_BLACK  = 2'd0,
        OSD_BLUE   = 2'd1,
        OSD_YELLOW = 2'd2,
        OSD_WHITE  = 2'd3
    } osd_color_e;

    // Analog output port modes
    typedef enum logic [1:0] {
        EXT_OFF   = 2'd0,
        EXT_RGBHV = 2'd1,
        EXT_RGBCS = 2'd2,
        EXT_RGSB  = 2'd3
    } ext_out_mode_e;

endpackage

/* logic/vout_cfg.svh */
`ifndef VOUT_CFG_SVH
`define VOUT_CFG_SVH

// Width of one color channel
`define VOUT_COLOR_W 8

// OSD replacement colors in R G B order
`define VOUT_OSD_BLACK  24'h000000
`define VOUT_OSD_BLUE   24'h0000ff
`define VOUT_OSD_YELLOW 24'hffff00
`define VOUT_OSD_WHITE  24'hffffff

// Input pixel to HDMI transmitter outputs
`define VOUT_HDMI_LAT 2

// Input pixel to analog DAC outputs
`define VOUT_VGA_LAT 3

`endif
